// File: cache_array.sv
`timescale 1ns/1ps

module cache_array import dcache_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [INDEX_BITS-1:0] lookup_index,
	input  logic [TAG_BITS-1:0]   lookup_tag,
	output cache_lookup_t         lookup,
	input  logic                  fill,
	input  logic [INDEX_BITS-1:0] fill_index,
	input  logic [TAG_BITS-1:0]   fill_tag,
	input  logic [WORD_WIDTH-1:0] fill_data
);

	logic [NUM_SETS-1:0]   valid;
	logic [TAG_BITS-1:0]   tags [NUM_SETS];
	logic [WORD_WIDTH-1:0] data [NUM_SETS];

	// reset empties the cache, a fill marks its line
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (fill) begin
			valid[fill_index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fill) begin
			tags[fill_index] <= fill_tag;
			data[fill_index] <= fill_data;
		end
	end

	// direct mapped, so one compare per lookup
	assign lookup.hit  = valid[lookup_index] && (tags[lookup_index] == lookup_tag);
	assign lookup.data = data[lookup_index];

	// looking up a just filled line must hit and return the written data
	property p_fill_lands;
		@(posedge clock) disable iff (reset)
		fill |=> !((lookup_index == $past(fill_index)) && (lookup_tag == $past(fill_tag))) ||
			(lookup.hit && (lookup.data == $past(fill_data)));
	endproperty

	a_fill_lands: assert property (p_fill_lands)
		else $error("cache_array: lookup of line %0d missed or wrong after fill", lookup_index);

endmodule

// File: dcache.sv
`timescale 1ns/1ps

module dcache import dcache_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  proc_request_t         proc_req,
	output logic [WORD_WIDTH-1:0] proc_data_out,
	output logic                  proc_valid,
	output mem_request_t          mem_req,
	input  mem_reply_t            mem_reply
);

	logic [INDEX_BITS-1:0]   current_index;
	logic [TAG_BITS-1:0]     current_tag;
	logic [INDEX_BITS-1:0]   last_index;
	logic [TAG_BITS-1:0]     last_tag;
	bus_command_t            last_command;
	logic [WORD_WIDTH-1:0]   last_data;
	logic [MEM_TAG_BITS-1:0] captured_tag;   // transaction tag of the load being waited on
	logic                    miss_outstanding;
	logic                    unanswered_miss;
	logic                    changed_req;
	logic                    load_fill;
	logic                    store_fill;
	logic                    fill;
	logic [WORD_WIDTH-1:0]   fill_data;
	cache_lookup_t           lookup;

	assign current_index = proc_req.addr[OFFSET_BITS +: INDEX_BITS];
	assign current_tag   = proc_req.addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];

	// new data under the same store address is a new request too
	assign changed_req = (current_index != last_index) || (current_tag != last_tag) ||
		(proc_req.command != last_command) ||
		((proc_req.command == BUS_STORE) && (proc_req.data != last_data));

	always_comb begin
		case (proc_req.command)
			BUS_LOAD:  proc_valid = lookup.hit;
			BUS_STORE: proc_valid = lookup.hit && !changed_req && !miss_outstanding;
			default:   proc_valid = 1'b0;
		endcase
	end

	assign proc_data_out = lookup.data;

	// bus request only goes out once the address has been registered
	assign mem_req.command = (miss_outstanding && !changed_req) ? proc_req.command : BUS_NONE;
	assign mem_req.addr    = {proc_req.addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	assign mem_req.data    = proc_req.data;

	// a stale return in the cycle the request changes must not fill the new line
	assign load_fill  = (captured_tag != '0) && (mem_reply.tag == captured_tag) && !changed_req;
	assign store_fill = (mem_req.command == BUS_STORE) && (mem_reply.response != '0);
	assign fill       = load_fill || store_fill;
	assign fill_data  = store_fill ? proc_req.data : mem_reply.data;

	// stores always go to memory, loads only on a miss
	assign unanswered_miss = changed_req ? ((proc_req.command != BUS_NONE) && !proc_valid) :
		(miss_outstanding && (mem_reply.response == '0));

	always_ff @(posedge clock) begin
		if (reset) begin
			last_index       <= '1;   // first request after reset looks new
			last_tag         <= '1;
			last_command     <= BUS_NONE;
			captured_tag     <= '0;
			miss_outstanding <= 1'b0;
		end else begin
			last_index       <= current_index;
			last_tag         <= current_tag;
			last_command     <= proc_req.command;
			miss_outstanding <= unanswered_miss;
			if (changed_req || miss_outstanding || load_fill) begin
				// zero unless a load was just accepted
				captured_tag <= (mem_req.command == BUS_LOAD) ? mem_reply.response : '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		last_data <= proc_req.data;
	end

	cache_array array_i (
		.clock        (clock),
		.reset        (reset),
		.lookup_index (current_index),
		.lookup_tag   (current_tag),
		.lookup       (lookup),
		.fill         (fill),
		.fill_index   (current_index),
		.fill_tag     (current_tag),
		.fill_data    (fill_data)
	);

	// an accepted offer clears the miss, so the bus is idle in the next cycle
	a_idle_bus: assert property (@(posedge clock) disable iff (reset)
		((mem_req.command != BUS_NONE) && (mem_reply.response != '0)) |=>
			(!miss_outstanding && (mem_req.command == BUS_NONE)))
		else $error("dcache: bus command %0d offered again after acceptance", mem_req.command);

	// the captured tag holds until its data arrives or the request changes
	a_tag_held: assert property (@(posedge clock) disable iff (reset)
		((captured_tag != '0) && !changed_req && !load_fill) |=> $stable(captured_tag))
		else $error("dcache: captured tag changed while waiting, now %h", captured_tag);

endmodule

// File: dcache_pkg.sv
package dcache_pkg;

	// processor and bus geometry
	localparam int ADDR_WIDTH  = 64;
	localparam int WORD_WIDTH  = 64;

	// cache geometry, one word per line
	localparam int NUM_SETS    = 32;
	localparam int INDEX_BITS  = 5;    // addr[7:3]
	localparam int TAG_BITS    = 8;    // addr[15:8]
	localparam int OFFSET_BITS = 3;    // byte within the word

	// memory model
	localparam int MEM_WORD_BITS = 13;   // 8192 words
	localparam int MEM_LATENCY   = 6;    // acceptance to data return
	localparam int MEM_TAG_BITS  = 4;    // tag 0 is no transaction

	// initial memory word is word address xor this
	localparam logic [WORD_WIDTH-1:0] MEM_INIT_PATTERN = 64'h5a3c_96e1_0f87_d2b4;

	typedef enum logic [1:0] {
		BUS_NONE  = 2'b00,
		BUS_LOAD  = 2'b01,
		BUS_STORE = 2'b10
	} bus_command_t;

	typedef struct packed {
		bus_command_t          command;
		logic [ADDR_WIDTH-1:0] addr;
		logic [WORD_WIDTH-1:0] data;   // store data
	} proc_request_t;

	typedef struct packed {
		bus_command_t          command;
		logic [ADDR_WIDTH-1:0] addr;   // word aligned
		logic [WORD_WIDTH-1:0] data;
	} mem_request_t;

	typedef struct packed {
		logic [MEM_TAG_BITS-1:0] response;   // tag given to the request this cycle
		logic [WORD_WIDTH-1:0]   data;
		logic [MEM_TAG_BITS-1:0] tag;        // tag of the data returned this cycle
	} mem_reply_t;

	typedef struct packed {
		logic                  hit;
		logic [WORD_WIDTH-1:0] data;
	} cache_lookup_t;

endpackage

// File: dcache_system.f
dcache_pkg.sv
cache_array.sv
dcache.sv
tagged_memory.sv
dcache_system.sv
tb_clock_gen.sv
dcache_system_tb.sv

// File: dcache_system.sv
`timescale 1ns/1ps

module dcache_system import dcache_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  proc_request_t         proc_req,
	output logic [WORD_WIDTH-1:0] proc_data_out,
	output logic                  proc_valid
);

	mem_request_t mem_req;     // cache to memory
	mem_reply_t   mem_reply;   // tags and returned data

	dcache dcache_i (
		.clock         (clock),
		.reset         (reset),
		.proc_req      (proc_req),
		.proc_data_out (proc_data_out),
		.proc_valid    (proc_valid),
		.mem_req       (mem_req),
		.mem_reply     (mem_reply)
	);

	tagged_memory memory_i (
		.clock     (clock),
		.reset     (reset),
		.mem_req   (mem_req),
		.mem_reply (mem_reply)
	);

endmodule

// File: dcache_system_tb.sv
`timescale 1ns/1ps

module dcache_system_tb import dcache_pkg::*; ();

	localparam int CLOCK_PERIOD_NS = 40;
	localparam int RESET_CYCLES    = 10;
	localparam int N_BASIC         = 8;   // miss/hit rounds and store/load rounds
	localparam int N_PAIR          = 6;   // shared index rounds, six ops each
	localparam int N_BURST         = 4;
	localparam int TOTAL_OPS       = 4 * N_BASIC + 6 * N_PAIR + 3 * N_BURST + 2;
	localparam longint WATCHDOG_NS =
		longint'(TOTAL_OPS * (MEM_LATENCY + 8) + RESET_CYCLES + 20) * CLOCK_PERIOD_NS;

	logic                  clock;
	logic                  reset;
	proc_request_t         proc_req;
	logic [WORD_WIDTH-1:0] proc_data_out;
	logic                  proc_valid;

	logic [WORD_WIDTH-1:0] expected_data;   // driven together with the request
	logic                  expect_hit;
	int                    op_age;          // cycles since the request appeared

	proc_request_t         prev_req;
	logic                  prev_valid;
	logic [WORD_WIDTH-1:0] prev_data_out;

	// reference memory, plus which tag each line should hold
	logic [WORD_WIDTH-1:0] ref_mem [logic [MEM_WORD_BITS-1:0]];
	logic [TAG_BITS-1:0]   model_tag [NUM_SETS];
	logic                  model_valid [NUM_SETS];

	integer seed;
	int     valid_errors  = 0;
	int     data_errors   = 0;
	int     timing_errors = 0;

	tb_clock_gen #(.PERIOD_NS(CLOCK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
		.clock (clock),
		.reset (reset)
	);

	dcache_system dut_i (
		.clock         (clock),
		.reset         (reset),
		.proc_req      (proc_req),
		.proc_data_out (proc_data_out),
		.proc_valid    (proc_valid)
	);

	always_ff @(posedge clock) begin
		prev_req      <= proc_req;
		prev_valid    <= proc_valid;
		prev_data_out <= proc_data_out;
	end

	a_quiet_when_idle: assert property (@(posedge clock)
		(reset || (proc_req.command == BUS_NONE)) |-> !proc_valid)
		else begin
			valid_errors++;
			$display("CHECK FAILED proc_valid expected %h got %h while idle",
				1'b0, $sampled(proc_valid));
		end

	a_data_matches: assert property (@(posedge clock) disable iff (reset)
		((proc_req.command != BUS_NONE) && proc_valid) |-> (proc_data_out == expected_data))
		else begin
			data_errors++;
			$display("CHECK FAILED proc_data_out expected %h got %h",
				$sampled(expected_data), $sampled(proc_data_out));
		end

	a_store_not_early: assert property (@(posedge clock) disable iff (reset)
		((proc_req.command == BUS_STORE) && (op_age < 2)) |-> !proc_valid)
		else begin
			timing_errors++;
			$display("CHECK FAILED proc_valid expected %h got %h in store cycle %0d",
				1'b0, $sampled(proc_valid), $sampled(op_age));
		end

	a_store_on_time: assert property (@(posedge clock) disable iff (reset)
		((proc_req.command == BUS_STORE) && (op_age == 2)) |-> proc_valid)
		else begin
			timing_errors++;
			$display("CHECK FAILED proc_valid expected %h got %h two cycles into a store",
				1'b1, $sampled(proc_valid));
		end

	a_hit_first_cycle: assert property (@(posedge clock) disable iff (reset)
		((proc_req.command == BUS_LOAD) && expect_hit && (op_age == 0)) |-> proc_valid)
		else begin
			timing_errors++;
			$display("CHECK FAILED proc_valid expected %h got %h on a load hit",
				1'b1, $sampled(proc_valid));
		end

	// a miss cannot finish before the memory latency plus request and fill cycles
	a_miss_not_early: assert property (@(posedge clock) disable iff (reset)
		((proc_req.command == BUS_LOAD) && !expect_hit && (op_age < MEM_LATENCY + 2))
		|-> !proc_valid)
		else begin
			timing_errors++;
			$display("CHECK FAILED proc_valid expected %h got %h in miss cycle %0d",
				1'b0, $sampled(proc_valid), $sampled(op_age));
		end

	a_valid_held: assert property (@(posedge clock) disable iff (reset)
		((proc_req == prev_req) && (proc_req.command != BUS_NONE) && prev_valid)
		|-> proc_valid)
		else begin
			valid_errors++;
			$display("CHECK FAILED proc_valid expected %h got %h on a held request",
				1'b1, $sampled(proc_valid));
		end

	a_data_held: assert property (@(posedge clock) disable iff (reset)
		((proc_req == prev_req) && (proc_req.command != BUS_NONE) && prev_valid)
		|-> (proc_data_out == prev_data_out))
		else begin
			data_errors++;
			$display("CHECK FAILED proc_data_out expected %h got %h on a held request",
				$sampled(prev_data_out), $sampled(proc_data_out));
		end

	function automatic logic [WORD_WIDTH-1:0] ref_read(input logic [MEM_WORD_BITS-1:0] word);
		if (ref_mem.exists(word)) begin
			return ref_mem[word];
		end
		return WORD_WIDTH'(word) ^ MEM_INIT_PATTERN;   // never stored
	endfunction

	function automatic logic [MEM_WORD_BITS-1:0] random_word();
		return MEM_WORD_BITS'($random(seed));
	endfunction

	function automatic logic [WORD_WIDTH-1:0] random_data();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic int random_hold();
		return $unsigned($random(seed)) % 4;
	endfunction

	// same index, different tag
	function automatic logic [MEM_WORD_BITS-1:0] alias_word(input logic [MEM_WORD_BITS-1:0] word);
		logic [TAG_BITS-1:0] flip;
		flip = TAG_BITS'($random(seed));
		if (flip == '0) begin
			flip = TAG_BITS'(1);
		end
		return word ^ {flip, INDEX_BITS'(0)};
	endfunction

	// one processor request, held until proc_valid and then for hold more cycles
	task automatic run_op(input bus_command_t cmd, input logic [MEM_WORD_BITS-1:0] word,
		input logic [WORD_WIDTH-1:0] data, input int hold, input bit idle_after);
		logic [INDEX_BITS-1:0]  index;
		logic [TAG_BITS-1:0]    tag;
		logic [OFFSET_BITS-1:0] offset;
		index  = word[INDEX_BITS-1:0];
		tag    = word[MEM_WORD_BITS-1 -: TAG_BITS];
		offset = OFFSET_BITS'($random(seed));   // byte offset is ignored by the cache
		@(posedge clock);
		proc_req.command <= cmd;
		proc_req.addr    <= ADDR_WIDTH'({word, offset});
		proc_req.data    <= data;
		expected_data    <= (cmd == BUS_STORE) ? data : ref_read(word);
		expect_hit       <= model_valid[index] && (model_tag[index] == tag);
		op_age           <= 0;
		@(negedge clock);
		while (!proc_valid) begin
			@(posedge clock);
			op_age <= op_age + 1;
			@(negedge clock);
		end
		model_valid[index] = 1'b1;   // loads and stores both allocate
		model_tag[index]   = tag;
		if (cmd == BUS_STORE) begin
			ref_mem[word] = data;
		end
		repeat (hold) begin
			@(posedge clock);
			op_age <= op_age + 1;
		end
		if (idle_after) begin
			@(posedge clock);
			proc_req.command <= BUS_NONE;
		end
	endtask

	task automatic load_twice();
		logic [MEM_WORD_BITS-1:0] word;
		for (int n = 0; n < N_BASIC; n++) begin
			word = random_word();
			run_op(BUS_LOAD, word, random_data(), random_hold(), 1'b1);
			run_op(BUS_LOAD, word, random_data(), random_hold(), 1'b1);
		end
	endtask

	task automatic store_then_load();
		logic [MEM_WORD_BITS-1:0] word;
		for (int n = 0; n < N_BASIC; n++) begin
			word = random_word();
			run_op(BUS_STORE, word, random_data(), random_hold(), 1'b1);
			run_op(BUS_LOAD, word, random_data(), random_hold(), 1'b1);
		end
	endtask

	// two words fight over one line, so loads alternate between eviction and refill
	task automatic alternate_shared_index();
		logic [MEM_WORD_BITS-1:0] word_a;
		logic [MEM_WORD_BITS-1:0] word_b;
		for (int n = 0; n < N_PAIR; n++) begin
			word_a = random_word();
			word_b = alias_word(word_a);
			run_op(BUS_LOAD, word_a, random_data(), random_hold(), 1'b1);
			run_op(BUS_STORE, word_b, random_data(), random_hold(), 1'b1);
			run_op(BUS_LOAD, word_a, random_data(), random_hold(), 1'b1);
			run_op(BUS_STORE, word_a, random_data(), random_hold(), 1'b1);
			run_op(BUS_LOAD, word_b, random_data(), random_hold(), 1'b1);
			run_op(BUS_LOAD, word_a, random_data(), random_hold(), 1'b1);
		end
	endtask

	// the aliased store evicts the line, so the miss is accepted while the first
	// store is still in the memory pipeline
	task automatic store_evict_reload();
		logic [INDEX_BITS-1:0]    base;
		logic [MEM_WORD_BITS-1:0] a_words [N_BURST];
		logic [MEM_WORD_BITS-1:0] b_words [N_BURST];
		base = INDEX_BITS'($random(seed));
		for (int k = 0; k < N_BURST; k++) begin
			a_words[k] = {TAG_BITS'($random(seed)), INDEX_BITS'(base + k)};
			b_words[k] = alias_word(a_words[k]);
		end
		for (int k = 0; k < N_BURST; k++) begin
			run_op(BUS_STORE, a_words[k], random_data(), 0, 1'b0);
			run_op(BUS_STORE, b_words[k], random_data(), 0, 1'b0);
			run_op(BUS_LOAD, a_words[k], random_data(), 0, k == N_BURST - 1);
		end
	endtask

	task automatic hold_after_valid();
		run_op(BUS_LOAD, random_word(), random_data(), 3, 1'b1);
		run_op(BUS_STORE, random_word(), random_data(), 3, 1'b1);
	endtask

	initial begin
		seed          = 32'h293e_d02f;
		proc_req      = '0;
		expected_data = '0;
		expect_hit    = 1'b0;
		op_age        = 0;
		for (int i = 0; i < NUM_SETS; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i]   = '0;
		end
		while (reset !== 1'b0) begin
			@(posedge clock);
		end
		repeat (2) @(posedge clock);
		load_twice();
		store_then_load();
		alternate_shared_index();
		store_evict_reload();
		hold_after_valid();
		repeat (4) @(posedge clock);
		$display("errors: valid %0d, data %0d, timing %0d",
			valid_errors, data_errors, timing_errors);
		if (valid_errors + data_errors + timing_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the dcache_system testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
	--top-module dcache_system_tb \
	-f dcache_system.f \
	--Mdir obj_dir -o dcache_system_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/dcache_system_sim > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see $SIM_LOG"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$SIM_LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $SIM_LOG"
	exit 1
fi

// File: tagged_memory.sv
`timescale 1ns/1ps

module tagged_memory import dcache_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  mem_request_t mem_req,
	output mem_reply_t   mem_reply
);

	typedef struct packed {
		bus_command_t             command;
		logic [MEM_WORD_BITS-1:0] word;
		logic [WORD_WIDTH-1:0]    data;
		logic [MEM_TAG_BITS-1:0]  tag;
	} mem_stage_t;

	logic [WORD_WIDTH-1:0]   storage [2**MEM_WORD_BITS];
	mem_stage_t              pipe [MEM_LATENCY];
	mem_stage_t              tail;
	logic [MEM_TAG_BITS-1:0] next_tag;   // zero while in reset, so requests are refused
	logic                    accept;

	// every word starts as its own address xor the pattern
	initial begin
		for (int i = 0; i < 2**MEM_WORD_BITS; i++) begin
			storage[i] = WORD_WIDTH'(i) ^ MEM_INIT_PATTERN;
		end
	end

	assign mem_reply.response = (mem_req.command != BUS_NONE) ? next_tag : '0;
	assign accept             = (mem_reply.response != '0);

	// tags run 1..15 and wrap, skipping 0
	always_ff @(posedge clock) begin
		if (reset) begin
			next_tag <= '0;
		end else if (accept || (next_tag == '0)) begin
			next_tag <= (next_tag == '1) ? MEM_TAG_BITS'(1) : next_tag + 1'b1;
		end
	end

	// fixed latency shift pipeline, one transaction per stage
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < MEM_LATENCY; i++) begin
				pipe[i] <= '0;
			end
		end else begin
			pipe[0].command <= accept ? mem_req.command : BUS_NONE;
			pipe[0].word    <= mem_req.addr[OFFSET_BITS +: MEM_WORD_BITS];
			pipe[0].data    <= mem_req.data;
			pipe[0].tag     <= mem_reply.response;
			for (int i = 1; i < MEM_LATENCY; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	assign tail = pipe[MEM_LATENCY-1];

	// loads read at the pipeline end, after every older store has written
	assign mem_reply.data = storage[tail.word];
	assign mem_reply.tag  = (tail.command == BUS_LOAD) ? tail.tag : '0;   // stores return no tag

	always @(posedge clock) begin
		if (tail.command == BUS_STORE) begin
			storage[tail.word] <= tail.data;
		end
	end

	// a returned tag belongs to the load it was handed to MEM_LATENCY cycles earlier
	a_tag_from_load: assert property (@(posedge clock) disable iff (reset)
		(mem_reply.tag != '0) |->
			(($past(mem_req.command, MEM_LATENCY) == BUS_LOAD) &&
			($past(mem_reply.response, MEM_LATENCY) == mem_reply.tag)))
		else $error("tagged_memory: tag %h returned without a matching load", mem_reply.tag);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clock = ~clock;
		end
	end

	// released on a rising edge, like any other driven input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
	end

endmodule
